//--- verilog/axi_rd_pkg.sv
// Shared bus widths, component latency and the burst, response and decode state enums
package axi_rd_pkg;

    // ------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------

    // Byte address width
    localparam int ADDR_W = 32;
    // Read data width
    localparam int DATA_W = 32;
    // Byte offset bits inside one data word
    localparam int STRB_W = 2;
    // Transaction ID width
    localparam int ID_W   = 4;
    // AxLEN and AxSIZE widths
    localparam int LEN_W  = 8;
    localparam int SIZE_W = 3;

    // ------------------------------------------------------------
    // Component timing
    // ------------------------------------------------------------

    // Cycles from an accepted request to valid read data, 0 means same cycle
    localparam int COMP_LAT   = 1;
    // Skid stages needed to absorb the beats in flight under back-pressure
    localparam int RESP_DEPTH = COMP_LAT + 1;

    // ------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    // EXOKAY and DECERR are never returned
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    // Decode state, idle or issuing beats of one burst
    typedef enum logic {
        RD_IDLE  = 1'b0,
        RD_BURST = 1'b1
    } rd_state_e;

endpackage

//--- verilog/axi_rd_ar_decode.sv
// AR channel decode: burst capture, beat down-counter and next beat address generation
`timescale 1ns/1ps

module axi_rd_ar_decode (
    input  logic                          clk,
    input  logic                          rst_n,
    // AR channel
    input  logic                          i_arvalid,
    output logic                          o_arready,
    input  logic [axi_rd_pkg::ADDR_W-1:0] i_araddr,
    input  logic [axi_rd_pkg::ID_W-1:0]   i_arid,
    input  logic [axi_rd_pkg::LEN_W-1:0]  i_arlen,
    input  logic [axi_rd_pkg::SIZE_W-1:0] i_arsize,
    input  axi_rd_pkg::axi_burst_e        i_arburst,
    // Beat request toward issue
    input  logic                          i_req_accept,
    output logic                          o_req_valid,
    output logic [axi_rd_pkg::ADDR_W-1:0] o_req_addr,
    output logic [axi_rd_pkg::ID_W-1:0]   o_req_id,
    output logic                          o_req_last
);

    axi_rd_pkg::rd_state_e state;

    // Current burst context, full byte address kept for narrow sizes
    logic [axi_rd_pkg::ADDR_W-1:0] ctx_addr;
    logic [axi_rd_pkg::ID_W-1:0]   ctx_id;
    logic [axi_rd_pkg::LEN_W-1:0]  ctx_len;
    logic [axi_rd_pkg::SIZE_W-1:0] ctx_size;
    axi_rd_pkg::axi_burst_e        ctx_burst;

    // Beats still to issue after the current one
    logic [axi_rd_pkg::LEN_W-1:0]  cnt;

    logic                          ar_hs;
    logic [axi_rd_pkg::ADDR_W-1:0] size_bytes;
    logic [axi_rd_pkg::ADDR_W-1:0] size_mask;
    logic [axi_rd_pkg::ADDR_W-1:0] wrap_len;
    logic [axi_rd_pkg::ADDR_W-1:0] wrap_mask;
    logic [axi_rd_pkg::ADDR_W-1:0] incr_addr;
    logic [axi_rd_pkg::ADDR_W-1:0] next_addr;

    // ------------------------------------------------------------
    // AR handshake
    // ------------------------------------------------------------

    // Ready again in the cycle the last beat goes out, no bubble between bursts
    assign o_arready = (state == axi_rd_pkg::RD_IDLE) || (i_req_accept && o_req_last);
    assign ar_hs     = i_arvalid && o_arready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= axi_rd_pkg::RD_IDLE;
            cnt   <= '0;
        end else if (ar_hs) begin
            state <= axi_rd_pkg::RD_BURST;
            cnt   <= i_arlen;
        end else if (i_req_accept) begin
            if (o_req_last) begin
                state <= axi_rd_pkg::RD_IDLE;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // Context follows the handshake, address steps on each accepted beat
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            ctx_addr  <= i_araddr;
            ctx_id    <= i_arid;
            ctx_len   <= i_arlen;
            ctx_size  <= i_arsize;
            ctx_burst <= i_arburst;
        end else if (i_req_accept) begin
            ctx_addr  <= next_addr;
        end
    end

    // ------------------------------------------------------------
    // Next beat address
    // ------------------------------------------------------------

    always_comb begin
        // Bytes per beat
        size_bytes = {{(axi_rd_pkg::ADDR_W-1){1'b0}}, 1'b1} << ctx_size;
        size_mask  = size_bytes - 1'b1;
        // Wrap window is (len+1) beats wide
        wrap_len   = {{(axi_rd_pkg::ADDR_W-axi_rd_pkg::LEN_W){1'b0}}, ctx_len} + 1'b1;
        wrap_mask  = (wrap_len << ctx_size) - 1'b1;
        // Later beats are size aligned even if the first one was not
        incr_addr  = (ctx_addr & ~size_mask) + size_bytes;
        case (ctx_burst)
            axi_rd_pkg::BURST_INCR: next_addr = incr_addr;
            axi_rd_pkg::BURST_WRAP: next_addr = (ctx_addr & ~wrap_mask) | (incr_addr & wrap_mask);
            default:                next_addr = ctx_addr;
        endcase
    end

    // Word aligned request to the component
    assign o_req_valid = (state == axi_rd_pkg::RD_BURST);
    assign o_req_addr  = {ctx_addr[axi_rd_pkg::ADDR_W-1:axi_rd_pkg::STRB_W],
                          {axi_rd_pkg::STRB_W{1'b0}}};
    assign o_req_id    = ctx_id;
    assign o_req_last  = (cnt == '0);

endmodule

//--- verilog/axi_rd_comp_issue.sv
// Component request issue and beat context shift register matched to the component latency
`timescale 1ns/1ps

module axi_rd_comp_issue (
    input  logic                        clk,
    input  logic                        rst_n,
    // Beat request from decode
    input  logic                        i_req_valid,
    input  logic [axi_rd_pkg::ID_W-1:0] i_req_id,
    input  logic                        i_req_last,
    output logic                        o_req_accept,
    // Component handshake
    output logic                        o_dv,
    input  logic                        i_hld,
    input  logic                        i_err,
    // Response pipe side
    input  logic                        i_space,
    output logic                        o_beat_valid,
    output logic [axi_rd_pkg::ID_W-1:0] o_beat_id,
    output logic                        o_beat_last,
    output axi_rd_pkg::axi_resp_e       o_beat_resp
);

    // Stage 0 is the acceptance cycle, stage COMP_LAT lines up with rdata
    logic                        vld_sr  [axi_rd_pkg::COMP_LAT+1];
    logic [axi_rd_pkg::ID_W-1:0] id_sr   [axi_rd_pkg::COMP_LAT+1];
    logic                        last_sr [axi_rd_pkg::COMP_LAT+1];

    // ------------------------------------------------------------
    // Request
    // ------------------------------------------------------------

    // Only ask when every response stage can take the result
    assign o_dv         = i_req_valid && i_space;
    assign o_req_accept = o_dv && !i_hld;

    assign vld_sr[0]  = o_req_accept;
    assign id_sr[0]   = i_req_id;
    assign last_sr[0] = i_req_last;

    // ------------------------------------------------------------
    // Context shift register
    // ------------------------------------------------------------

    // Empty for zero latency, context then passes straight through
    for (genvar k = 1; k <= axi_rd_pkg::COMP_LAT; k++) begin : g_ctx

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                vld_sr[k] <= 1'b0;
            end else begin
                vld_sr[k] <= vld_sr[k-1];
            end
        end

        always_ff @(posedge clk) begin
            id_sr[k]   <= id_sr[k-1];
            last_sr[k] <= last_sr[k-1];
        end

    end

    // Tail of the pipe meets the component data
    assign o_beat_valid = vld_sr[axi_rd_pkg::COMP_LAT];
    assign o_beat_id    = id_sr[axi_rd_pkg::COMP_LAT];
    assign o_beat_last  = last_sr[axi_rd_pkg::COMP_LAT];
    // Error from the component turns into SLVERR for this beat only
    assign o_beat_resp  = i_err ? axi_rd_pkg::RESP_SLVERR : axi_rd_pkg::RESP_OKAY;

endmodule

//--- verilog/axi_rd_resp_pipe.sv
// R channel response pipe built from a chain of two-entry skid buffers
`timescale 1ns/1ps

module axi_rd_resp_pipe (
    input  logic                          clk,
    input  logic                          rst_n,
    // Beat from issue, always accepted
    input  logic                          i_beat_valid,
    input  logic [axi_rd_pkg::ID_W-1:0]   i_beat_id,
    input  logic                          i_beat_last,
    input  axi_rd_pkg::axi_resp_e         i_beat_resp,
    input  logic [axi_rd_pkg::DATA_W-1:0] i_rdata,
    output logic                          o_space,
    // R channel
    output logic                          o_rvalid,
    input  logic                          i_rready,
    output logic [axi_rd_pkg::DATA_W-1:0] o_rdata,
    output logic [axi_rd_pkg::ID_W-1:0]   o_rid,
    output axi_rd_pkg::axi_resp_e         o_rresp,
    output logic                          o_rlast
);

    // One beat of payload and context
    typedef struct packed {
        logic [axi_rd_pkg::DATA_W-1:0] data;
        logic [axi_rd_pkg::ID_W-1:0]   id;
        axi_rd_pkg::axi_resp_e         resp;
        logic                          last;
    } beat_t;

    // Index 0 is the pipe input, RESP_DEPTH the R channel
    logic                        stg_vld  [axi_rd_pkg::RESP_DEPTH+1];
    beat_t                       stg_beat [axi_rd_pkg::RESP_DEPTH+1];
    logic [axi_rd_pkg::RESP_DEPTH:0] stg_rdy;

    assign stg_vld[0]  = i_beat_valid;
    assign stg_beat[0] = '{data: i_rdata, id: i_beat_id, resp: i_beat_resp, last: i_beat_last};
    assign stg_rdy[axi_rd_pkg::RESP_DEPTH] = i_rready;

    // ------------------------------------------------------------
    // Skid stages
    // ------------------------------------------------------------

    for (genvar k = 0; k < axi_rd_pkg::RESP_DEPTH; k++) begin : g_stage

        logic  skd_vld;
        beat_t skd_beat;
        logic  out_free;

        // Output register can load when empty or draining
        assign out_free   = !stg_vld[k+1] || stg_rdy[k+1];
        // Upstream may send while the skid entry is empty
        assign stg_rdy[k] = !skd_vld;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                stg_vld[k+1] <= 1'b0;
                skd_vld      <= 1'b0;
            end else if (out_free) begin
                stg_vld[k+1] <= skd_vld || stg_vld[k];
                skd_vld      <= 1'b0;
            end else if (stg_vld[k] && stg_rdy[k]) begin
                // Output stalled, park the new beat
                skd_vld      <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (out_free) begin
                // Parked beat is older and goes first
                stg_beat[k+1] <= skd_vld ? skd_beat : stg_beat[k];
            end else if (stg_vld[k] && stg_rdy[k]) begin
                skd_beat      <= stg_beat[k];
            end
        end

    end

    // Room for the worst case only when no stage has a parked beat
    assign o_space  = &stg_rdy[axi_rd_pkg::RESP_DEPTH-1:0];

    assign o_rvalid = stg_vld[axi_rd_pkg::RESP_DEPTH];
    assign o_rdata  = stg_beat[axi_rd_pkg::RESP_DEPTH].data;
    assign o_rid    = stg_beat[axi_rd_pkg::RESP_DEPTH].id;
    assign o_rresp  = stg_beat[axi_rd_pkg::RESP_DEPTH].resp;
    assign o_rlast  = stg_beat[axi_rd_pkg::RESP_DEPTH].last;

endmodule

//--- verilog/axi_rd_sub.sv
// AXI read subordinate top level joining AR decode, component issue and response pipe
`timescale 1ns/1ps

module axi_rd_sub (
    input  logic                          clk,
    input  logic                          rst_n,
    // AR channel
    input  logic                          i_arvalid,
    output logic                          o_arready,
    input  logic [axi_rd_pkg::ADDR_W-1:0] i_araddr,
    input  logic [axi_rd_pkg::ID_W-1:0]   i_arid,
    input  logic [axi_rd_pkg::LEN_W-1:0]  i_arlen,
    input  logic [axi_rd_pkg::SIZE_W-1:0] i_arsize,
    input  axi_rd_pkg::axi_burst_e        i_arburst,
    // R channel
    output logic                          o_rvalid,
    input  logic                          i_rready,
    output logic [axi_rd_pkg::DATA_W-1:0] o_rdata,
    output logic [axi_rd_pkg::ID_W-1:0]   o_rid,
    output axi_rd_pkg::axi_resp_e         o_rresp,
    output logic                          o_rlast,
    // Component
    output logic                          o_dv,
    output logic [axi_rd_pkg::ADDR_W-1:0] o_addr,
    input  logic                          i_hld,
    input  logic                          i_err,
    input  logic [axi_rd_pkg::DATA_W-1:0] i_rdata
);

    // Decode and issue
    logic                        req_valid;
    logic [axi_rd_pkg::ID_W-1:0] req_id;
    logic                        req_last;
    logic                        req_accept;

    // Issue and response pipe
    logic                        space;
    logic                        beat_valid;
    logic [axi_rd_pkg::ID_W-1:0] beat_id;
    logic                        beat_last;
    axi_rd_pkg::axi_resp_e       beat_resp;

    axi_rd_ar_decode u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_arvalid    (i_arvalid),
        .o_arready    (o_arready),
        .i_araddr     (i_araddr),
        .i_arid       (i_arid),
        .i_arlen      (i_arlen),
        .i_arsize     (i_arsize),
        .i_arburst    (i_arburst),
        .i_req_accept (req_accept),
        .o_req_valid  (req_valid),
        .o_req_addr   (o_addr),
        .o_req_id     (req_id),
        .o_req_last   (req_last)
    );

    axi_rd_comp_issue u_issue (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_req_valid  (req_valid),
        .i_req_id     (req_id),
        .i_req_last   (req_last),
        .o_req_accept (req_accept),
        .o_dv         (o_dv),
        .i_hld        (i_hld),
        .i_err        (i_err),
        .i_space      (space),
        .o_beat_valid (beat_valid),
        .o_beat_id    (beat_id),
        .o_beat_last  (beat_last),
        .o_beat_resp  (beat_resp)
    );

    // Component data joins its context at the pipe input
    axi_rd_resp_pipe u_resp (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_beat_valid (beat_valid),
        .i_beat_id    (beat_id),
        .i_beat_last  (beat_last),
        .i_beat_resp  (beat_resp),
        .i_rdata      (i_rdata),
        .o_space      (space),
        .o_rvalid     (o_rvalid),
        .i_rready     (i_rready),
        .o_rdata      (o_rdata),
        .o_rid        (o_rid),
        .o_rresp      (o_rresp),
        .o_rlast      (o_rlast)
    );

endmodule

//--- dv/axi_rd_sub_chk.sv
// Concurrent AR, R and component port assertions, bound into the read subordinate top level
`timescale 1ns/1ps

module axi_rd_sub_chk (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          i_arvalid,
    input logic                          o_arready,
    input logic [axi_rd_pkg::ADDR_W-1:0] i_araddr,
    input logic [axi_rd_pkg::ID_W-1:0]   i_arid,
    input logic [axi_rd_pkg::LEN_W-1:0]  i_arlen,
    input logic [axi_rd_pkg::SIZE_W-1:0] i_arsize,
    input axi_rd_pkg::axi_burst_e        i_arburst,
    input logic                          o_rvalid,
    input logic                          i_rready,
    input logic [axi_rd_pkg::DATA_W-1:0] o_rdata,
    input logic [axi_rd_pkg::ID_W-1:0]   o_rid,
    input axi_rd_pkg::axi_resp_e         o_rresp,
    input logic                          o_rlast,
    input logic                          o_dv,
    input logic [axi_rd_pkg::ADDR_W-1:0] o_addr
);

    // AR request held with a stable payload until accepted
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        i_arvalid && !o_arready |=> i_arvalid &&
            $stable({i_araddr, i_arid, i_arlen, i_arsize, i_arburst}))
        else $error("AR valid dropped or payload changed while stalled");

    // R beat held with a stable payload under back-pressure
    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        o_rvalid && !i_rready |=> o_rvalid && $stable({o_rdata, o_rid, o_rresp, o_rlast}))
        else $error("R valid dropped or payload changed while stalled");

    // Component requests are always word aligned
    addr_align: assert property (@(posedge clk) disable iff (!rst_n)
        o_dv |-> (o_addr[axi_rd_pkg::STRB_W-1:0] == '0))
        else $error("Component address not word aligned");

endmodule

bind axi_rd_sub axi_rd_sub_chk u_chk (.*);

//--- dv/axi_rd_sub_tb.sv
// Testbench with clock, reset, AR driver, component model, reference queues and R beat checker
`timescale 1ns/1ps

module axi_rd_sub_tb;

    // Component data pattern and the address bit that flags an error
    localparam logic [31:0] DATA_PAT = 32'h5ac3_0f96;
    localparam int          ERR_BIT  = 12;
    localparam int          TIMEOUT  = 2000;
    localparam int          SEED     = 46512;
    localparam int          LAT      = axi_rd_pkg::COMP_LAT;

    logic                          clk = 1'b0;
    logic                          rst_n;
    logic                          i_arvalid;
    logic                          o_arready;
    logic [axi_rd_pkg::ADDR_W-1:0] i_araddr;
    logic [axi_rd_pkg::ID_W-1:0]   i_arid;
    logic [axi_rd_pkg::LEN_W-1:0]  i_arlen;
    logic [axi_rd_pkg::SIZE_W-1:0] i_arsize;
    axi_rd_pkg::axi_burst_e        i_arburst;
    logic                          o_rvalid;
    logic                          i_rready;
    logic [axi_rd_pkg::DATA_W-1:0] o_rdata;
    logic [axi_rd_pkg::ID_W-1:0]   o_rid;
    axi_rd_pkg::axi_resp_e         o_rresp;
    logic                          o_rlast;
    logic                          o_dv;
    logic [axi_rd_pkg::ADDR_W-1:0] o_addr;
    logic                          i_hld;
    logic                          i_err;
    logic [axi_rd_pkg::DATA_W-1:0] i_rdata;

    // Stall percentages of the current burst
    int hld_pct  = 0;
    int stall_pct = 0;

    // Expected R beats in issue order
    logic [31:0] exp_data [$];
    logic [3:0]  exp_id   [$];
    logic [1:0]  exp_resp [$];
    logic        exp_last [$];

    // Component address and acceptance pipelines, entry LAT lines up with the returned data
    logic [31:0] lat_addr [LAT+1] = '{default: '0};
    logic        lat_vld  [LAT+1] = '{default: 1'b0};
    logic [31:0] comp_addr;
    logic        comp_vld;

    axi_rd_sub i_dut (.*);

    always #2 clk = ~clk;

    // ------------------------------------------------------------
    // Failure reporting and the single compare task
    // ------------------------------------------------------------

    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ------------------------------------------------------------
    // Component model
    // ------------------------------------------------------------

    // Address and acceptance move one stage per clock, outputs change 1 ns after the edge
    always @(posedge clk) begin
        for (int k = LAT; k >= 1; k--) begin
            lat_addr[k] <= #1 (k == 1) ? o_addr : lat_addr[k-1];
            lat_vld[k]  <= #1 (k == 1) ? (o_dv && !i_hld) : lat_vld[k-1];
        end
    end

    assign comp_addr = (LAT == 0) ? o_addr : lat_addr[LAT];
    assign comp_vld  = (LAT == 0) ? (o_dv && !i_hld) : lat_vld[LAT];
    // Data only for an accepted request, unknown otherwise
    assign i_rdata   = comp_vld ? (comp_addr ^ DATA_PAT) : 'x;
    assign i_err     = comp_addr[ERR_BIT];

    // Random hold and rready stalls, one seeded stream
    initial begin
        void'($urandom(SEED));
        i_hld    = 1'b0;
        i_rready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            i_hld    = ($urandom % 100) < hld_pct;
            i_rready = ($urandom % 100) >= stall_pct;
        end
    end

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------

    // Byte address of beat n by the AXI burst rules
    function automatic logic [31:0] beat_addr(input logic [31:0] addr, input logic [7:0] len,
                                              input logic [2:0] size, input logic [1:0] burst,
                                              input int n);
        logic [31:0] bytes;
        logic [31:0] aligned;
        logic [31:0] window;
        logic [31:0] base;
        bytes   = 32'd1 << size;
        aligned = addr & ~(bytes - 1);
        window  = (len + 32'd1) * bytes;
        base    = addr & ~(window - 1);
        if (n == 0 || burst == 2'd0) begin
            return addr;
        end else if (burst == 2'd2) begin
            return base + ((aligned - base + n * bytes) % window);
        end
        return aligned + n * bytes;
    endfunction

    task automatic push_expected(input logic [3:0] id, input logic [31:0] addr,
                                 input logic [7:0] len, input logic [2:0] size,
                                 input logic [1:0] burst);
        logic [31:0] word;
        for (int n = 0; n <= len; n++) begin
            word = beat_addr(addr, len, size, burst, n) & ~32'h3;
            exp_data.push_back(word ^ DATA_PAT);
            exp_id.push_back(id);
            // SLVERR is per beat
            exp_resp.push_back(word[ERR_BIT] ? 2'b10 : 2'b00);
            exp_last.push_back(n == len);
        end
    endtask

    // ------------------------------------------------------------
    // AR driver
    // ------------------------------------------------------------

    // Entered 1 ns after an edge, leaves 1 ns after the handshake edge
    task automatic send_burst(input logic [3:0] id, input logic [31:0] addr,
                              input logic [7:0] len, input logic [2:0] size,
                              input logic [1:0] burst);
        int cnt;
        cnt       = 0;
        i_arvalid = 1'b1;
        i_arid    = id;
        i_araddr  = addr;
        i_arlen   = len;
        i_arsize  = size;
        i_arburst = axi_rd_pkg::axi_burst_e'(burst);
        @(negedge clk);
        while (!o_arready) begin
            cnt++;
            if (cnt > TIMEOUT) begin
                fail_with("AR request was never accepted");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        i_arvalid = 1'b0;
    endtask

    // R beats are checked mid-cycle, the transfer lands on the next edge
    always @(negedge clk) begin
        if (rst_n && o_rvalid && i_rready) begin
            if (exp_data.size() == 0) begin
                fail_with("R beat returned with no beat outstanding");
            end else begin
                check_value("o_rdata", o_rdata, exp_data.pop_front());
                check_value("o_rid", o_rid, exp_id.pop_front());
                check_value("o_rresp", o_rresp, exp_resp.pop_front());
                check_value("o_rlast", o_rlast, exp_last.pop_front());
            end
        end
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial begin
        int          fd;
        int          n;
        int          cnt;
        string       line;
        logic [31:0] f_id;
        logic [31:0] f_addr;
        logic [31:0] f_len;
        logic [31:0] f_size;
        logic [31:0] f_burst;
        int          f_hld;
        int          f_stall;
        rst_n     = 1'b0;
        i_arvalid = 1'b0;
        i_araddr  = '0;
        i_arid    = '0;
        i_arlen   = '0;
        i_arsize  = '0;
        i_arburst = axi_rd_pkg::BURST_INCR;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Idle outputs before any request
        @(negedge clk);
        check_value("o_arready", o_arready, 1'b1);
        check_value("o_dv", o_dv, 1'b0);
        check_value("o_rvalid", o_rvalid, 1'b0);

        fd = $fopen("dv/axi_rd_input.txt", "r");
        if (fd == 0) begin
            fail_with("Cannot open the burst input file");
        end
        @(posedge clk);
        #1;
        while (!$feof(fd)) begin
            // A read past the end leaves the line empty
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %h %h %d %d", f_id, f_addr, f_len, f_size,
                        f_burst, f_hld, f_stall);
            // Comment and blank lines give fewer fields
            if (n == 7 && line.substr(0, 0) != "#") begin
                hld_pct   = f_hld;
                stall_pct = f_stall;
                push_expected(f_id[3:0], f_addr, f_len[7:0], f_size[2:0], f_burst[1:0]);
                send_burst(f_id[3:0], f_addr, f_len[7:0], f_size[2:0], f_burst[1:0]);
            end
        end
        $fclose(fd);

        // Drain every outstanding beat
        cnt = 0;
        while (exp_data.size() != 0) begin
            cnt++;
            if (cnt > TIMEOUT) begin
                fail_with("Not all expected R beats were returned");
            end
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- axi_rd_sub.f
verilog/axi_rd_pkg.sv
verilog/axi_rd_ar_decode.sv
verilog/axi_rd_comp_issue.sv
verilog/axi_rd_resp_pipe.sv
verilog/axi_rd_sub.sv
dv/axi_rd_sub_chk.sv
dv/axi_rd_sub_tb.sv

//--- dv/axi_rd_input.txt
# One burst per line: id addr len size burst (hex), hld_pct rready_stall_pct (decimal)
# Burst codes 0 FIXED, 1 INCR, 2 WRAP, bit 12 of a beat address returns SLVERR
1 00000100 00 2 1 0 0
2 00000200 03 2 1 0 0
3 00000301 07 0 1 0 0
4 00000402 05 1 1 0 0
5 00000518 03 2 2 0 0
6 00000606 07 1 2 0 0
7 00000704 0f 0 2 0 0
8 00000800 03 2 0 0 0
9 00001010 02 2 1 0 0
a 00000ff8 03 2 1 0 0
b 00002000 0f 2 1 30 30
c 0000302c 03 2 2 20 50
d 00000ff0 07 2 1 40 40
e 00000900 02 1 0 25 60
f 00004000 1f 2 1 50 50
0 00001ffc 00 2 1 10 70
1 00005004 07 0 1 30 30
2 000060a0 07 2 2 50 20
